//--- common/snakePkg.sv
`default_nettype none

package snakePkg;

    // framebuffer size in pixels
    localparam int screenWidth = 160;
    localparam int screenHeight = 120;

    // side of the apple and of every segment
    localparam int blockSize = 10;

    // fixed snake length, head included
    localparam int segmentCount = 4;

    // coordinate widths, enough for 160 and 120
    localparam int xWidth = 8;
    localparam int yWidth = 7;

    // head start position, body trails to the left
    localparam int startHeadX = 80;
    localparam int startHeadY = 60;

    // apple block origin
    localparam int appleX = 30;
    localparam int appleY = 30;

    // clocks between two snake steps
    localparam int stepCycles = 2048;

    // one bit each for red, green, blue
    typedef logic [2:0] colourT;

    localparam colourT appleColour = 3'b100;
    localparam colourT eraseColour = 3'b000;

    // block origin on the screen
    typedef struct packed
    {
        logic [xWidth-1:0] x;
        logic [yWidth-1:0] y;
    } pointT;

    // element 0 is the head
    typedef pointT [segmentCount-1:0] segmentArrayT;

    typedef enum logic [1:0]
    {
        headingRight,
        headingDown,
        headingUp,
        headingLeft
    } headingT;

    // frame loop states
    typedef enum logic [2:0]
    {
        stateIdle,
        statePaintApple,
        statePaintBody,
        stateWaitStep,
        stateEraseBody,
        stateCheckHit,
        stateMoveSnake,
        stateGameOver
    } gameStateT;

endpackage

`default_nettype wire

//--- common/paintIf.sv
`default_nettype none

// one block paint request, requester side holds origin and colour with start
interface paintIf
    import snakePkg::*;
();

    // single cycle request strobe
    logic start;
    // top left corner of the block
    pointT origin;
    colourT colour;
    // single cycle, after the last pixel went out
    logic done;

    modport requester
    (
        output start,
        output origin,
        output colour,
        input done
    );

    modport painter
    (
        input start,
        input origin,
        input colour,
        output done
    );

endinterface

`default_nettype wire

//--- game/gameControl.sv
`default_nettype none

module gameControl
    import snakePkg::*;
(
    input logic Clock,
    input logic reset,
    input logic start,
    input logic keyRight,
    input logic keyDown,
    input logic keyUp,
    input logic keyLeft,
    input colourT bodyColour,
    input segmentArrayT segments,
    input logic hit,
    output headingT heading,
    output logic moveStep,
    output logic gameOver,
    paintIf.requester paint
);

    gameStateT state;
    gameStateT nextState;

    // free running step timer
    logic [$clog2(stepCycles)-1:0] tickCount;
    logic stepTick;

    // segment walked by the paint and erase loops
    logic [$clog2(segmentCount)-1:0] segIndex;
    logic lastSegment;

    // request for the current block already sent
    logic paintIssued;
    logic painting;

    assign stepTick = (tickCount == stepCycles - 1);
    assign lastSegment = (segIndex == segmentCount - 1);

    // apple, body and erase all go through the painter
    assign painting = (state == statePaintApple) || (state == statePaintBody)
        || (state == stateEraseBody);
    assign paint.start = painting && !paintIssued;

    // snake advances for exactly one cycle per frame
    assign moveStep = (state == stateMoveSnake);

    always_comb
    begin
        // apple is fixed, otherwise the selected segment
        if (state == statePaintApple)
        begin
            paint.origin.x = xWidth'(appleX);
            paint.origin.y = yWidth'(appleY);
            paint.colour = appleColour;
        end
        else
        begin
            paint.origin = segments[segIndex];
            paint.colour = (state == stateEraseBody) ? eraseColour : bodyColour;
        end
    end

    always_comb
    begin
        nextState = state;
        case (state)
            stateIdle:
                if (start)
                    nextState = statePaintApple;
            statePaintApple:
                if (paint.done)
                    nextState = statePaintBody;
            statePaintBody:
                if (paint.done && lastSegment)
                    nextState = stateWaitStep;
            stateWaitStep:
                if (stepTick)
                    nextState = stateEraseBody;
            stateEraseBody:
                if (paint.done && lastSegment)
                    nextState = stateCheckHit;
            // single cycle decision on the current head
            stateCheckHit:
                nextState = hit ? stateGameOver : stateMoveSnake;
            stateMoveSnake:
                nextState = statePaintApple;
            // parked until reset
            stateGameOver:
                nextState = stateGameOver;
            default:
                nextState = stateIdle;
        endcase
    end

    always_ff @(posedge Clock)
    begin
        if (reset)
        begin
            state <= stateIdle;
            tickCount <= '0;
            segIndex <= '0;
            paintIssued <= 1'b0;
            gameOver <= 1'b0;
            heading <= headingRight;
        end
        else
        begin
            state <= nextState;
            // tick period counts from reset, not from the frame
            tickCount <= stepTick ? '0 : tickCount + 1'b1;
            // rearm after each finished block
            if (paint.done)
                paintIssued <= 1'b0;
            else if (paint.start)
                paintIssued <= 1'b1;
            // next segment, wrap to the head after the tail
            if (paint.done && (state != statePaintApple))
                segIndex <= lastSegment ? '0 : segIndex + 1'b1;
            if ((state == stateCheckHit) && hit)
                gameOver <= 1'b1;
            // key priority right, down, up, left
            if (keyRight)
                heading <= headingRight;
            else if (keyDown)
                heading <= headingDown;
            else if (keyUp)
                heading <= headingUp;
            else if (keyLeft)
                heading <= headingLeft;
        end
    end

endmodule

`default_nettype wire

//--- game/snakeBody.sv
`default_nettype none

module snakeBody
    import snakePkg::*;
(
    input logic Clock,
    input logic reset,
    input logic moveStep,
    input headingT heading,
    output segmentArrayT segments
);

    // head position one block further along the heading
    pointT nextHead;

    always_comb
    begin
        nextHead = segments[0];
        case (heading)
            headingRight:
                nextHead.x = segments[0].x + xWidth'(blockSize);
            headingLeft:
                nextHead.x = segments[0].x - xWidth'(blockSize);
            headingDown:
                nextHead.y = segments[0].y + yWidth'(blockSize);
            headingUp:
                nextHead.y = segments[0].y - yWidth'(blockSize);
            default:
                nextHead = segments[0];
        endcase
    end

    always_ff @(posedge Clock)
    begin
        if (reset)
        begin
            // horizontal row, tail to the left of the head
            for (int i = 0; i < segmentCount; i++)
            begin
                segments[i].x <= xWidth'(startHeadX - i * blockSize);
                segments[i].y <= yWidth'(startHeadY);
            end
        end
        else if (moveStep)
        begin
            segments[0] <= nextHead;
            // each segment takes the old place of the one ahead
            for (int i = 1; i < segmentCount; i++)
            begin
                segments[i] <= segments[i-1];
            end
        end
    end

endmodule

`default_nettype wire

//--- game/collisionCheck.sv
`default_nettype none

module collisionCheck
    import snakePkg::*;
(
    input segmentArrayT segments,
    output logic hit
);

    logic onEdge;
    // one flag per body segment
    logic [segmentCount-1:1] overlap;

    // head on the outermost ring of blocks
    assign onEdge = (segments[0].x == '0)
        || (segments[0].x == xWidth'(screenWidth - blockSize))
        || (segments[0].y == '0)
        || (segments[0].y == yWidth'(screenHeight - blockSize));

    always_comb
    begin
        overlap = '0;
        // box overlap with one extra bit so the sums cannot wrap
        for (int i = 1; i < segmentCount; i++)
        begin
            overlap[i] = ({1'b0, segments[0].x} < {1'b0, segments[i].x} + blockSize)
                && ({1'b0, segments[i].x} < {1'b0, segments[0].x} + blockSize)
                && ({1'b0, segments[0].y} < {1'b0, segments[i].y} + blockSize)
                && ({1'b0, segments[i].y} < {1'b0, segments[0].y} + blockSize);
        end
    end

    assign hit = onEdge || (|overlap);

endmodule

`default_nettype wire

//--- render/blockPainter.sv
`default_nettype none

module blockPainter
    import snakePkg::*;
(
    input logic Clock,
    input logic reset,
    paintIf.painter paint,
    input logic pixelReady,
    output logic [xWidth-1:0] pixelX,
    output logic [yWidth-1:0] pixelY,
    output colourT pixelColour,
    output logic plot
);

    // block in progress
    logic busy;
    pointT originReg;
    colourT colourReg;

    // position inside the block
    logic [$clog2(blockSize)-1:0] colCount;
    logic [$clog2(blockSize)-1:0] rowCount;

    logic accepted;
    logic lastPixel;

    assign accepted = busy && pixelReady;
    assign lastPixel = (colCount == blockSize - 1) && (rowCount == blockSize - 1);

    // address and colour only move on an accepted pixel, so they hold under stall
    assign plot = busy;
    assign pixelX = originReg.x + xWidth'(colCount);
    assign pixelY = originReg.y + yWidth'(rowCount);
    assign pixelColour = colourReg;

    always_ff @(posedge Clock)
    begin
        if (reset)
        begin
            busy <= 1'b0;
            colCount <= '0;
            rowCount <= '0;
            paint.done <= 1'b0;
        end
        else
        begin
            // one cycle after the final pixel is taken
            paint.done <= accepted && lastPixel;
            if (!busy)
            begin
                // new request only when idle
                if (paint.start)
                begin
                    busy <= 1'b1;
                    colCount <= '0;
                    rowCount <= '0;
                end
            end
            else if (pixelReady)
            begin
                // row major scan
                if (lastPixel)
                begin
                    busy <= 1'b0;
                end
                else if (colCount == blockSize - 1)
                begin
                    colCount <= '0;
                    rowCount <= rowCount + 1'b1;
                end
                else
                begin
                    colCount <= colCount + 1'b1;
                end
            end
        end
    end

    // request fields held for the whole block
    always_ff @(posedge Clock)
    begin
        if (!busy && paint.start)
        begin
            originReg <= paint.origin;
            colourReg <= paint.colour;
        end
    end

endmodule

`default_nettype wire

//--- rtl/snakeTop.sv
`default_nettype none

module snakeTop
    import snakePkg::*;
(
    input logic Clock,
    input logic reset,
    input logic start,
    input logic keyRight,
    input logic keyDown,
    input logic keyUp,
    input logic keyLeft,
    input colourT bodyColour,
    input logic pixelReady,
    output logic [xWidth-1:0] pixelX,
    output logic [yWidth-1:0] pixelY,
    output colourT pixelColour,
    output logic plot,
    output logic gameOver
);

    // snake state shared by control and hit check
    segmentArrayT segments;
    headingT heading;
    logic moveStep;
    logic hit;

    // block requests from control to painter
    paintIf paintBus ();

    gameControl control0
    (
        .Clock(Clock),
        .reset(reset),
        .start(start),
        .keyRight(keyRight),
        .keyDown(keyDown),
        .keyUp(keyUp),
        .keyLeft(keyLeft),
        .bodyColour(bodyColour),
        .segments(segments),
        .hit(hit),
        .heading(heading),
        .moveStep(moveStep),
        .gameOver(gameOver),
        .paint(paintBus.requester)
    );

    snakeBody body0
    (
        .Clock(Clock),
        .reset(reset),
        .moveStep(moveStep),
        .heading(heading),
        .segments(segments)
    );

    collisionCheck collision0
    (
        .segments(segments),
        .hit(hit)
    );

    blockPainter painter0
    (
        .Clock(Clock),
        .reset(reset),
        .paint(paintBus.painter),
        .pixelReady(pixelReady),
        .pixelX(pixelX),
        .pixelY(pixelY),
        .pixelColour(pixelColour),
        .plot(plot)
    );

endmodule

`default_nettype wire

//--- verification/snakeTop_asserts.sv
`default_nettype none

module snakeTopAsserts
    import snakePkg::*;
(
    input logic Clock,
    input logic reset,
    input logic start,
    input colourT bodyColour,
    input logic pixelReady,
    input logic [xWidth-1:0] pixelX,
    input logic [yWidth-1:0] pixelY,
    input colourT pixelColour,
    input logic plot,
    input logic gameOver
);

    timeunit 1ns;
    timeprecision 100ps;

    // failures seen so far, polled by the testbench
    int errorCount = 0;

    logic seenStart;
    logic accepted;
    logic inApple;
    // last cycle's pixel port
    logic [xWidth-1:0] heldX;
    logic [yWidth-1:0] heldY;
    colourT heldColour;

    assign accepted = plot && pixelReady;
    assign inApple = (int'(pixelX) >= appleX) && (int'(pixelX) < appleX + blockSize)
        && (int'(pixelY) >= appleY) && (int'(pixelY) < appleY + blockSize);

    always_ff @(posedge Clock)
    begin
        if (reset)
            seenStart <= 1'b0;
        else if (start)
            seenStart <= 1'b1;
        heldX <= pixelX;
        heldY <= pixelY;
        heldColour <= pixelColour;
    end

    // quiet until the first start
    idleQuiet: assert property (@(posedge Clock) disable iff (reset)
        !seenStart |-> !plot && !gameOver)
        else
        begin
            errorCount++;
            $error("ERROR %0t plot gameOver expected 0 0 got %0b %0b", $time, plot, gameOver);
        end

    onScreen: assert property (@(posedge Clock) disable iff (reset)
        accepted |-> (int'(pixelX) < screenWidth) && (int'(pixelY) < screenHeight))
        else
        begin
            errorCount++;
            $error("ERROR %0t pixelX pixelY outside screen got %0d %0d", $time, pixelX, pixelY);
        end

    // red only on the apple
    appleColourOnly: assert property (@(posedge Clock) disable iff (reset)
        accepted |-> inApple ? (pixelColour == appleColour)
            : ((pixelColour == bodyColour) || (pixelColour == eraseColour)))
        else
        begin
            errorCount++;
            $error("ERROR %0t pixelColour expected %0d or %0d got %0d", $time,
                inApple ? appleColour : bodyColour, eraseColour, pixelColour);
        end

    // stalled pixel stays put
    stallHold: assert property (@(posedge Clock) disable iff (reset)
        plot && !pixelReady |=> plot && (pixelX == heldX) && (pixelY == heldY)
            && (pixelColour == heldColour))
        else
        begin
            errorCount++;
            $error("ERROR %0t pixelX pixelY pixelColour expected %0d %0d %0d got %0d %0d %0d",
                $time, heldX, heldY, heldColour, pixelX, pixelY, pixelColour);
        end

    // game over is final until reset
    overSticky: assert property (@(posedge Clock) disable iff (reset)
        gameOver |=> gameOver && !plot)
        else
        begin
            errorCount++;
            $error("ERROR %0t gameOver plot expected 1 0 got %0b %0b", $time, gameOver, plot);
        end

endmodule

bind snakeTop snakeTopAsserts asserts0
(
    .Clock(Clock),
    .reset(reset),
    .start(start),
    .bodyColour(bodyColour),
    .pixelReady(pixelReady),
    .pixelX(pixelX),
    .pixelY(pixelY),
    .pixelColour(pixelColour),
    .plot(plot),
    .gameOver(gameOver)
);

`default_nettype wire

//--- verification/snakeTb.sv
`default_nettype none

module snakeTb
    import snakePkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    // longest game ends on the wall at head x 150
    localparam int maxFrames = 8;
    // two games of two step periods per frame plus slack for stalls
    localparam int marginCycles = 14464;
    localparam int timeoutCycles = 2 * maxFrames * 2 * stepCycles + marginCycles;
    localparam int idleCycles = 20;
    localparam int settleCycles = 300;
    localparam int resetCycles = 3;
    localparam logic [31:0] randomSeed = 32'h8abb_2a9e;
    localparam colourT green = 3'b010;

    logic Clock = 1'b0;
    logic reset;
    logic start;
    logic keyRight;
    logic keyDown;
    logic keyUp;
    logic keyLeft;
    colourT bodyColour;
    logic pixelReady;
    logic [xWidth-1:0] pixelX;
    logic [yWidth-1:0] pixelY;
    colourT pixelColour;
    logic plot;
    logic gameOver;

    int frameCount;
    int cycleCount = 0;

    snakeTop dut0
    (
        .Clock(Clock),
        .reset(reset),
        .start(start),
        .keyRight(keyRight),
        .keyDown(keyDown),
        .keyUp(keyUp),
        .keyLeft(keyLeft),
        .bodyColour(bodyColour),
        .pixelReady(pixelReady),
        .pixelX(pixelX),
        .pixelY(pixelY),
        .pixelColour(pixelColour),
        .plot(plot),
        .gameOver(gameOver)
    );

    // 4 ns period
    always #2 Clock = ~Clock;

    task automatic reportFailure();
        $display("*** FAILED ***");
        $fatal(1, "run stopped at the first error");
    endtask

    // framebuffer stalls about one pixel in four
    initial
    begin
        pixelReady = 1'b1;
        void'($urandom(randomSeed));
        forever
        begin
            @(negedge Clock);
            pixelReady <= (($urandom % 4) != 0);
        end
    end

    // one accepted apple corner pixel per frame
    always @(posedge Clock)
    begin
        if (reset)
            frameCount <= 0;
        else if (plot && pixelReady && (pixelX == appleX) && (pixelY == appleY))
            frameCount <= frameCount + 1;
    end

    // watchdog over the whole run
    always @(posedge Clock)
    begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= timeoutCycles)
        begin
            $display("timeout, the game did not end within %0d cycles", timeoutCycles);
            reportFailure();
        end
    end

    // stop at the first failed assertion
    always @(negedge Clock)
    begin
        if (dut0.asserts0.errorCount != 0)
        begin
            $display("an assertion on the DUT outputs failed");
            reportFailure();
        end
    end

    // one game from reset to game over and its frame count
    task automatic runGame(input logic holdLeft, input int expectedFrames);
        @(negedge Clock);
        reset = 1'b1;
        start = 1'b0;
        keyLeft = 1'b0;
        repeat (resetCycles) @(negedge Clock);
        reset = 1'b0;
        // idle screen before start
        repeat (idleCycles) @(negedge Clock);
        start = 1'b1;
        keyLeft = holdLeft;
        @(negedge Clock);
        start = 1'b0;
        while (!gameOver)
            @(negedge Clock);
        // frozen screen after the hit
        repeat (settleCycles) @(negedge Clock);
        if (frameCount != expectedFrames)
        begin
            $display("ERROR %0t frameCount expected %0d got %0d", $time, expectedFrames,
                frameCount);
            reportFailure();
        end
    endtask

    initial
    begin
        reset = 1'b1;
        start = 1'b0;
        keyRight = 1'b0;
        keyDown = 1'b0;
        keyUp = 1'b0;
        keyLeft = 1'b0;
        bodyColour = green;
        // straight right into the wall
        runGame(1'b0, maxFrames);
        // turn back onto the body
        runGame(1'b1, 2);
        if (dut0.asserts0.errorCount == 0)
        begin
            $display("*** PASSED ***");
            $finish;
        end
        else
        begin
            reportFailure();
        end
    end

endmodule

`default_nettype wire

//--- sim.f
common/snakePkg.sv
common/paintIf.sv
game/gameControl.sv
game/snakeBody.sv
game/collisionCheck.sv
render/blockPainter.sv
rtl/snakeTop.sv
verification/snakeTop_asserts.sv
verification/snakeTb.sv

//--- Bender.yml
package:
  name: snake

sources:
  - common/snakePkg.sv
  - common/paintIf.sv
  - game/gameControl.sv
  - game/snakeBody.sv
  - game/collisionCheck.sv
  - render/blockPainter.sv
  - rtl/snakeTop.sv
  - target: test
    files:
      - verification/snakeTop_asserts.sv
      - verification/snakeTb.sv
